// File: verilog/pad_geom_pkg.sv
/*
 * Block geometry for the mirror-padding DMA: buffer sizes, the nine block
 * kinds and the descriptor that travels from the sequencer to the datapath
 */
package pad_geom_pkg;

    localparam int BLK_DIM = 4;  // Source words per block edge
    localparam int BUF_DIM = 5;  // Block plus one pad word

    typedef logic [5:0] width_t;
    typedef logic [5:0] blk_idx_t;
    typedef logic [2:0] lane_idx_t;
    typedef logic [2:0] col_idx_t;

    typedef enum logic [3:0] {TL, TR, BL, BR, T, B, L, R, INNER} blk_kind_e;

    typedef struct packed {
        blk_idx_t  bx;
        blk_idx_t  by;
        blk_kind_e kind;
    } blk_desc_t;

    // Which sides of the matrix a block touches
    function automatic logic is_top(input blk_kind_e k);
        return k inside {TL, TR, T};
    endfunction

    function automatic logic is_bottom(input blk_kind_e k);
        return k inside {BL, BR, B};
    endfunction

    function automatic logic is_left(input blk_kind_e k);
        return k inside {TL, BL, L};
    endfunction

    function automatic logic is_right(input blk_kind_e k);
        return k inside {TR, BR, R};
    endfunction

endpackage

// File: verilog/mem_bus_pkg.sv
/*
 * Memory bus types shared by the reader, the writer and the row lanes
 */
package mem_bus_pkg;

    localparam int unsigned WORD_BYTES = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  burst_len_t;  // Beats minus one

    // One buffer row with index 0 as the leftmost column
    typedef word_t [4:0] lane_row_t;

endpackage

// File: verilog/lane_fill_if.sv
/*
 * Beat path from the block reader into the five buffer row lanes.
 * A lane stores the word when wr_en is high and lane_sel names it.
 */
`timescale 1ns/1ps

interface lane_fill_if;
    import mem_bus_pkg::*;
    import pad_geom_pkg::*;

    logic      wr_en;
    lane_idx_t lane_sel;  // Target buffer row
    col_idx_t  col;
    word_t     data;

    modport reader (output wr_en, lane_sel, col, data);
    modport lane   (input  wr_en, lane_sel, col, data);

endinterface

// File: verilog/block_sequencer.sv
/*
 * Job control for the padding DMA. Latches the job on start, walks the
 * 4x4 blocks in row-major order and steps each through fetch, pad and write.
 */
`timescale 1ns/1ps

module block_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mem_bus_pkg::addr_t      src_addr_i,
    input  mem_bus_pkg::addr_t      dst_addr_i,
    input  pad_geom_pkg::width_t    mat_width_i,
    input  logic                    start_i,
    output logic                    done_o,
    output mem_bus_pkg::addr_t      src_addr_o,
    output mem_bus_pkg::addr_t      dst_addr_o,
    output pad_geom_pkg::width_t    width_o,
    output pad_geom_pkg::blk_desc_t desc_o,
    output logic                    fetch_start_o,
    input  logic                    fetch_done_i,
    output logic                    pad_step_o,
    output logic                    write_start_o,
    input  logic                    write_done_i
);
    import mem_bus_pkg::*;
    import pad_geom_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_FETCH, S_PAD, S_WRITE} state_e;

    state_e    state_q;
    addr_t     src_q;
    addr_t     dst_q;
    width_t    width_q;
    blk_idx_t  last_q;  // Index of the last block per row and column
    blk_desc_t desc_q;
    logic      job_ok;
    logic      accept;
    blk_idx_t  next_bx;
    blk_idx_t  next_by;

    // Corners first, then edges
    function automatic blk_kind_e classify(input blk_idx_t bx, input blk_idx_t by,
                                           input blk_idx_t last);
        logic top, bot, lft, rgt;
        top = (by == '0);
        bot = (by == last);
        lft = (bx == '0);
        rgt = (bx == last);
        if (top && lft)      return TL;
        else if (top && rgt) return TR;
        else if (bot && lft) return BL;
        else if (bot && rgt) return BR;
        else if (top)        return T;
        else if (bot)        return B;
        else if (lft)        return L;
        else if (rgt)        return R;
        return INNER;
    endfunction

    // A single block cannot be padded, so at least two per side
    assign job_ok  = (mat_width_i[1:0] == 2'b00) && (mat_width_i >= width_t'(2 * BLK_DIM));
    assign accept  = (state_q == S_IDLE) && start_i && job_ok;
    assign next_bx = (desc_q.bx == last_q) ? '0 : desc_q.bx + 6'd1;
    assign next_by = (desc_q.bx == last_q) ? desc_q.by + 6'd1 : desc_q.by;

    always_ff @(posedge clk) begin
        fetch_start_o <= 1'b0;
        pad_step_o    <= 1'b0;
        write_start_o <= 1'b0;
        if (!rst_n) begin
            state_q <= S_IDLE;
            done_o  <= 1'b1;
            desc_q  <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (accept) begin
                    done_o        <= 1'b0;
                    desc_q        <= '{bx: '0, by: '0, kind: TL};
                    fetch_start_o <= 1'b1;
                    state_q       <= S_FETCH;
                end
                S_FETCH: if (fetch_done_i) begin
                    pad_step_o <= 1'b1;
                    state_q    <= S_PAD;
                end
                S_PAD: begin
                    write_start_o <= 1'b1;
                    state_q       <= S_WRITE;
                end
                S_WRITE: if (write_done_i) begin
                    if (desc_q.bx == last_q && desc_q.by == last_q) begin
                        done_o  <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        desc_q        <= '{bx: next_bx, by: next_by,
                                           kind: classify(next_bx, next_by, last_q)};
                        fetch_start_o <= 1'b1;
                        state_q       <= S_FETCH;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Job configuration
    always_ff @(posedge clk) begin
        if (accept) begin
            src_q   <= src_addr_i;
            dst_q   <= dst_addr_i;
            width_q <= mat_width_i;
            last_q  <= (mat_width_i >> 2) - 6'd1;
        end
    end

    assign src_addr_o = src_q;
    assign dst_addr_o = dst_q;
    assign width_o    = width_q;
    assign desc_o     = desc_q;

endmodule

// File: verilog/block_reader.sv
/*
 * Fetches one source block as four 4-beat read bursts, one per block row,
 * and steers each beat to its lane and column in the block buffer
 */
`timescale 1ns/1ps

module block_reader #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_start_i,
    input  mem_bus_pkg::addr_t      src_addr_i,
    input  pad_geom_pkg::width_t    width_i,
    input  pad_geom_pkg::blk_desc_t desc_i,
    output logic                    fetch_done_o,
    lane_fill_if.reader             fill,
    output mem_bus_pkg::addr_t      araddr_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,
    input  mem_bus_pkg::word_t      rdata_i,
    input  logic                    rlast_i,
    input  logic                    rvalid_i,
    output logic                    rready_o
);
    import mem_bus_pkg::*;
    import pad_geom_pkg::*;

    logic [1:0] row_q;   // Block row being fetched
    logic [1:0] beat_q;
    logic       ar_fire;
    logic       r_fire;

    if (ADDR_W != $bits(addr_t) || DATA_W != $bits(word_t)) begin : g_width_check
        $error("block_reader bus widths differ from mem_bus_pkg");
    end

    // Byte address of source row 4*by+k, column 4*bx
    function automatic addr_t row_addr(input logic [1:0] k);
        addr_t src_row, src_col;
        src_row = desc_i.by * BLK_DIM;
        src_row = src_row + k;
        src_col = desc_i.bx * BLK_DIM;
        return src_addr_i + (src_row * width_i + src_col) * WORD_BYTES;
    endfunction

    assign ar_fire      = arvalid_o & arready_i;
    assign r_fire       = rvalid_i & rready_o;
    assign fetch_done_o = r_fire & rlast_i & (row_q == 2'd3);

    // Top and left blocks leave row 0 / column 0 free for the pad
    assign fill.wr_en    = r_fire;
    assign fill.lane_sel = lane_idx_t'(row_q) + (is_top(desc_i.kind) ? 3'd1 : 3'd0);
    assign fill.col      = col_idx_t'(beat_q) + (is_left(desc_i.kind) ? 3'd1 : 3'd0);
    assign fill.data     = rdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid_o <= 1'b0;
            rready_o  <= 1'b0;
            row_q     <= '0;
            beat_q    <= '0;
        end else if (fetch_start_i) begin
            row_q     <= '0;
            arvalid_o <= 1'b1;
        end else if (ar_fire) begin
            arvalid_o <= 1'b0;
            rready_o  <= 1'b1;
            beat_q    <= '0;
        end else if (r_fire) begin
            beat_q <= beat_q + 2'd1;
            if (rlast_i) begin
                rready_o <= 1'b0;
                if (row_q != 2'd3) begin
                    row_q     <= row_q + 2'd1;
                    arvalid_o <= 1'b1;  // Next row request
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start_i)
            araddr_o <= row_addr(2'd0);
        else if (r_fire && rlast_i)
            araddr_o <= row_addr(row_q + 2'd1);
    end

endmodule

// File: verilog/pad_row_lane.sv
/*
 * One row of the 5x5 block buffer. Stores read beats addressed to it and
 * applies the reflective pad of its row in a single step.
 */
`timescale 1ns/1ps

module pad_row_lane #(
    parameter int LANE_INDEX = 0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    lane_fill_if.lane               fill,
    input  logic                    pad_step_i,
    input  pad_geom_pkg::blk_desc_t desc_i,
    input  mem_bus_pkg::lane_row_t  mirror_i,
    output mem_bus_pkg::lane_row_t  row_o
);
    import mem_bus_pkg::*;
    import pad_geom_pkg::*;

    lane_row_t row_q;
    lane_row_t base;
    lane_row_t padded;
    logic      hit;
    logic      use_mirror;

    assign hit = fill.wr_en && (fill.lane_sel == lane_idx_t'(LANE_INDEX));

    // Outer pad rows copy the row two away from the edge
    assign use_mirror = (LANE_INDEX == 0 && is_top(desc_i.kind)) ||
                        (LANE_INDEX == BUF_DIM - 1 && is_bottom(desc_i.kind));
    assign base = use_mirror ? mirror_i : row_q;

    always_comb begin
        padded = base;
        if (is_left(desc_i.kind))
            padded[0] = base[2];
        if (is_right(desc_i.kind))
            padded[BUF_DIM-1] = base[2];
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            row_q <= '0;
        else if (pad_step_i)
            row_q <= padded;
        else if (hit)
            row_q[fill.col] <= fill.data;
    end

    assign row_o = row_q;

endmodule

// File: verilog/block_writer.sv
/*
 * Writes the padded block to the destination, one burst per output row.
 * Each row waits for its write response before the next address goes out.
 */
`timescale 1ns/1ps

module block_writer #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       write_start_i,
    input  mem_bus_pkg::addr_t         dst_addr_i,
    input  pad_geom_pkg::width_t       width_i,
    input  pad_geom_pkg::blk_desc_t    desc_i,
    input  mem_bus_pkg::lane_row_t [pad_geom_pkg::BUF_DIM-1:0] rows_i,
    output logic                       write_done_o,
    output mem_bus_pkg::addr_t         awaddr_o,
    output mem_bus_pkg::burst_len_t    awlen_o,
    output logic                       awvalid_o,
    input  logic                       awready_i,
    output mem_bus_pkg::word_t         wdata_o,
    output logic                       wlast_o,
    output logic                       wvalid_o,
    input  logic                       wready_i,
    input  logic                       bvalid_i,
    output logic                       bready_o
);
    import mem_bus_pkg::*;
    import pad_geom_pkg::*;

    lane_idx_t row_q;     // Output row and source lane
    lane_idx_t last_row;
    col_idx_t  beat_q;
    logic      top_k;
    logic      left_k;
    logic      aw_fire;
    logic      w_fire;
    logic      b_fire;

    if (ADDR_W != $bits(addr_t) || DATA_W != $bits(word_t)) begin : g_width_check
        $error("block_writer bus widths differ from mem_bus_pkg");
    end

    assign top_k  = is_top(desc_i.kind);
    assign left_k = is_left(desc_i.kind);

    // Pad rows and columns widen the block to five
    assign last_row = (top_k || is_bottom(desc_i.kind)) ? lane_idx_t'(BUF_DIM - 1)
                                                        : lane_idx_t'(BLK_DIM - 1);
    assign awlen_o  = (left_k || is_right(desc_i.kind)) ? burst_len_t'(BUF_DIM - 1)
                                                        : burst_len_t'(BLK_DIM - 1);

    // Row i lands at padded row r0+i, column c0, pitch W+2
    function automatic addr_t row_addr(input lane_idx_t i);
        addr_t pad_row, pad_col, pitch;
        pad_row = desc_i.by * BLK_DIM;
        pad_row = pad_row + i + (top_k ? 0 : 1);
        pad_col = desc_i.bx * BLK_DIM;
        pad_col = pad_col + (left_k ? 0 : 1);
        pitch   = width_i + 2;
        return dst_addr_i + (pad_row * pitch + pad_col) * WORD_BYTES;
    endfunction

    assign aw_fire = awvalid_o & awready_i;
    assign w_fire  = wvalid_o & wready_i;
    assign b_fire  = bvalid_i & bready_o;

    assign wdata_o      = rows_i[row_q][beat_q];
    assign wlast_o      = wvalid_o & (burst_len_t'(beat_q) == awlen_o);
    assign write_done_o = b_fire & (row_q == last_row);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b0;
            bready_o  <= 1'b0;
            row_q     <= '0;
            beat_q    <= '0;
        end else if (write_start_i) begin
            row_q     <= '0;
            awvalid_o <= 1'b1;
        end else if (aw_fire) begin
            awvalid_o <= 1'b0;
            wvalid_o  <= 1'b1;
            beat_q    <= '0;
        end else if (w_fire) begin
            beat_q <= beat_q + 3'd1;
            if (wlast_o) begin
                wvalid_o <= 1'b0;
                bready_o <= 1'b1;  // Hold until the response
            end
        end else if (b_fire) begin
            bready_o <= 1'b0;
            if (row_q != last_row) begin
                row_q     <= row_q + 3'd1;
                awvalid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_start_i)
            awaddr_o <= row_addr('0);
        else if (b_fire)
            awaddr_o <= row_addr(row_q + 3'd1);
    end

endmodule

// File: verilog/pad_dma_top.sv
/*
 * Mirror-padding DMA engine. Copies a WxW word matrix into a (W+2)x(W+2)
 * reflected copy over valid/ready read and write channels.
 */
`timescale 1ns/1ps

module pad_dma_top #(
    parameter int ADDR_W = 32,
    parameter int DATA_W = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [ADDR_W-1:0]       src_addr_i,
    input  logic [ADDR_W-1:0]       dst_addr_i,
    input  pad_geom_pkg::width_t    mat_width_i,
    input  logic                    start_i,
    output logic                    done_o,
    // Read channels
    output logic [ADDR_W-1:0]       araddr_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,
    input  logic [DATA_W-1:0]       rdata_i,
    input  logic                    rlast_i,
    input  logic                    rvalid_i,
    output logic                    rready_o,
    // Write channels
    output logic [ADDR_W-1:0]       awaddr_o,
    output mem_bus_pkg::burst_len_t awlen_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output logic [DATA_W-1:0]       wdata_o,
    output logic                    wlast_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,
    input  logic                    bvalid_i,
    output logic                    bready_o
);
    import mem_bus_pkg::*;
    import pad_geom_pkg::*;

    addr_t                   src_addr;
    addr_t                   dst_addr;
    width_t                  width;
    blk_desc_t               desc;
    logic                    fetch_start;
    logic                    fetch_done;
    logic                    pad_step;
    logic                    write_start;
    logic                    write_done;
    lane_row_t [BUF_DIM-1:0] lane_rows;

    lane_fill_if i_fill ();

    block_sequencer i_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .src_addr_i    (src_addr_i),
        .dst_addr_i    (dst_addr_i),
        .mat_width_i   (mat_width_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .src_addr_o    (src_addr),
        .dst_addr_o    (dst_addr),
        .width_o       (width),
        .desc_o        (desc),
        .fetch_start_o (fetch_start),
        .fetch_done_i  (fetch_done),
        .pad_step_o    (pad_step),
        .write_start_o (write_start),
        .write_done_i  (write_done)
    );

    block_reader #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_reader (
        .clk           (clk),
        .rst_n         (rst_n),
        .fetch_start_i (fetch_start),
        .src_addr_i    (src_addr),
        .width_i       (width),
        .desc_i        (desc),
        .fetch_done_o  (fetch_done),
        .fill          (i_fill),
        .araddr_o      (araddr_o),
        .arvalid_o     (arvalid_o),
        .arready_i     (arready_i),
        .rdata_i       (rdata_i),
        .rlast_i       (rlast_i),
        .rvalid_i      (rvalid_i),
        .rready_o      (rready_o)
    );

    // Lane 2 holds the rows two away from the top and bottom pads
    for (genvar g = 0; g < BUF_DIM; g++) begin : g_lane
        pad_row_lane #(.LANE_INDEX(g)) i_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .fill       (i_fill),
            .pad_step_i (pad_step),
            .desc_i     (desc),
            .mirror_i   (lane_rows[2]),
            .row_o      (lane_rows[g])
        );
    end

    block_writer #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) i_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .write_start_i (write_start),
        .dst_addr_i    (dst_addr),
        .width_i       (width),
        .desc_i        (desc),
        .rows_i        (lane_rows),
        .write_done_o  (write_done),
        .awaddr_o      (awaddr_o),
        .awlen_o       (awlen_o),
        .awvalid_o     (awvalid_o),
        .awready_i     (awready_i),
        .wdata_o       (wdata_o),
        .wlast_o       (wlast_o),
        .wvalid_o      (wvalid_o),
        .wready_i      (wready_i),
        .bvalid_i      (bvalid_i),
        .bready_o      (bready_o)
    );

endmodule

// File: dv/pad_dma_sva.sv
/*
 * Protocol assertions for the padding DMA, bound to the top level.
 * Covers reset values, payload hold under stalls and burst framing.
 */
`timescale 1ns/1ps

module pad_dma_sva (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    done_o,
    input mem_bus_pkg::addr_t      araddr_o,
    input logic                    arvalid_o,
    input logic                    arready_i,
    input logic                    rlast_i,
    input logic                    rvalid_i,
    input logic                    rready_o,
    input mem_bus_pkg::addr_t      awaddr_o,
    input mem_bus_pkg::burst_len_t awlen_o,
    input logic                    awvalid_o,
    input logic                    awready_i,
    input mem_bus_pkg::word_t      wdata_o,
    input logic                    wlast_o,
    input logic                    wvalid_o,
    input logic                    wready_i,
    input logic                    bvalid_i,
    input logic                    bready_o
);
    import mem_bus_pkg::*;

    int unsigned fail_count = 0;
    burst_len_t  w_beats;  // Data beats sent in the current burst

    always_ff @(posedge clk) begin
        if (!rst_n)
            w_beats <= '0;
        else if (awvalid_o && awready_i)
            w_beats <= '0;
        else if (wvalid_o && wready_i)
            w_beats <= w_beats + 4'd1;
    end

    // Reset leaves the engine idle with every handshake quiet
    a_reset_idle: assert property (@(posedge clk) !rst_n |=> done_o && !arvalid_o &&
                                   !rready_o && !awvalid_o && !wvalid_o && !bready_o)
        else begin fail_count++; $error("engine not idle after reset"); end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else begin fail_count++; $error("read address dropped or changed while stalled"); end

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                awvalid_o && !awready_i |=>
                                awvalid_o && $stable(awaddr_o) && $stable(awlen_o))
        else begin fail_count++; $error("write address dropped or changed while stalled"); end

    a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
                               wvalid_o && !wready_i |=>
                               wvalid_o && $stable(wdata_o) && $stable(wlast_o))
        else begin fail_count++; $error("write data dropped or changed while stalled"); end

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
                               bready_o && !bvalid_i |=> bready_o)
        else begin fail_count++; $error("bready dropped before the response"); end

    // Last beat is number awlen+1
    a_wlast_beat: assert property (@(posedge clk) disable iff (!rst_n)
                                   wvalid_o |-> wlast_o == (w_beats == awlen_o))
        else begin fail_count++; $error("wlast on the wrong beat"); end

    a_rlast_end: assert property (@(posedge clk) disable iff (!rst_n)
                                  rvalid_i && rready_o && rlast_i |=> !rready_o)
        else begin fail_count++; $error("read burst continued past rlast"); end

endmodule

bind pad_dma_top pad_dma_sva i_sva (.*);

// File: dv/tb_pad_dma.sv
/*
 * Testbench for the mirror-padding DMA. A memory model with random ready
 * stalls serves reads and checks every write against the reflected source.
 */
`timescale 1ns/1ps

module tb_pad_dma;

    localparam logic [31:0] SRC_BASE     = 32'h0001_0000;
    localparam logic [31:0] DST_BASE     = 32'h0004_0000;
    localparam int          DONE_TIMEOUT = 20000;  // Cycles per job
    localparam int          IDLE_WINDOW  = 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] src_addr_i;
    logic [31:0] dst_addr_i;
    logic [5:0]  mat_width_i;
    logic        start_i;
    logic        done_o;
    logic [31:0] araddr_o;
    logic        arvalid_o;
    logic        arready_i;
    logic [31:0] rdata_i;
    logic        rlast_i;
    logic        rvalid_i;
    logic        rready_o;
    logic [31:0] awaddr_o;
    logic [3:0]  awlen_o;
    logic        awvalid_o;
    logic        awready_i;
    logic [31:0] wdata_o;
    logic        wlast_o;
    logic        wvalid_o;
    logic        wready_i;
    logic        bvalid_i;
    logic        bready_o;

    integer      seed = 32'h70a09005;
    logic [31:0] rnd;
    int          errors = 0;
    int          jobs = 0;
    bit          timed_out = 1'b0;
    int          job_w = 8;
    int unsigned hits [0:255];  // Writes per padded position

    // Memory model state
    logic [31:0] rd_addr = '0;
    int          rd_beat = 0;
    logic        rd_busy = 1'b0;
    logic [31:0] wr_addr = '0;
    int          wr_beat = 0;
    logic        resp_pending = 1'b0;

    pad_dma_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .mat_width_i (mat_width_i),
        .start_i     (start_i),
        .done_o      (done_o),
        .araddr_o    (araddr_o),
        .arvalid_o   (arvalid_o),
        .arready_i   (arready_i),
        .rdata_i     (rdata_i),
        .rlast_i     (rlast_i),
        .rvalid_i    (rvalid_i),
        .rready_o    (rready_o),
        .awaddr_o    (awaddr_o),
        .awlen_o     (awlen_o),
        .awvalid_o   (awvalid_o),
        .awready_i   (awready_i),
        .wdata_o     (wdata_o),
        .wlast_o     (wlast_o),
        .wvalid_o    (wvalid_o),
        .wready_i    (wready_i),
        .bvalid_i    (bvalid_i),
        .bready_o    (bready_o)
    );

    always #5 clk = ~clk;

    // Source contents depend on the whole word index
    function automatic logic [31:0] src_word(input int idx);
        return (32'(idx) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    // Reflect about the edge without repeating it
    function automatic int refl(input int k, input int w);
        if (k < 0)
            return 1;
        if (k >= w)
            return w - 2;
        return k;
    endfunction

    task automatic check_write_beat();
        int          pw;
        int          pos;
        int          r;
        int          c;
        logic [31:0] off;
        logic [31:0] exp;
        bit          in_range;
        pw       = job_w + 2;
        off      = wr_addr + 32'(wr_beat * 4) - DST_BASE;
        in_range = (off[1:0] == 2'b00) && (off < 32'(pw * pw * 4));
        assert (in_range) else begin
            $display("Write to %h lies outside the padded region", wr_addr + 32'(wr_beat * 4));
            errors++;
        end
        if (in_range) begin
            pos = int'(off >> 2);
            r   = pos / pw;
            c   = pos % pw;
            assert (hits[pos] == 0) else begin
                $display("Padded position (%0d,%0d) written more than once", r, c);
                errors++;
            end
            hits[pos]++;
            exp = src_word(refl(r - 1, job_w) * job_w + refl(c - 1, job_w));
            assert (wdata_o == exp) else begin
                $display("CHECK FAILED wdata_o at (%0d,%0d): got %h, expected %h",
                         r, c, wdata_o, exp);
                errors++;
            end
        end
    endtask

    // Memory side samples at the falling edge and drives after the rising edge
    always begin
        @(negedge clk);
        if (arvalid_o && arready_i) begin
            rd_addr = araddr_o;
            rd_beat = 0;
            rd_busy = 1'b1;
        end else if (rvalid_i && rready_o) begin
            rd_beat++;
            if (rd_beat == 4)
                rd_busy = 1'b0;
        end
        if (awvalid_o && awready_i) begin
            wr_addr = awaddr_o;
            wr_beat = 0;
        end
        if (wvalid_o && wready_i) begin
            check_write_beat();
            wr_beat++;
            if (wlast_o)
                resp_pending = 1'b1;
        end
        if (bvalid_i && bready_o)
            resp_pending = 1'b0;
        @(posedge clk);
        #1;
        rnd       = $random(seed);
        arready_i = rnd[1:0] != 2'b00;  // Ready three cycles in four
        awready_i = rnd[3:2] != 2'b00;
        wready_i  = rnd[5:4] != 2'b00;
        rvalid_i  = rd_busy;
        rlast_i   = rd_busy && rd_beat == 3;
        rdata_i   = src_word(int'((rd_addr - SRC_BASE) >> 2) + rd_beat);
        bvalid_i  = resp_pending && rnd[7:6] != 2'b00;  // Response may lag
    end

    task automatic print_job_result(input int w, input int errs_before);
        if (errors == errs_before)
            $display("Job width %0d: ok", w);
        else
            $display("Job width %0d: %0d failed checks", w, errors - errs_before);
    endtask

    task automatic run_job(input int w);
        int errs_before;
        int cycles;
        int missing;
        int i;
        errs_before = errors;
        job_w       = w;
        for (i = 0; i < 256; i++)
            hits[i] = 0;
        @(posedge clk);
        #1;
        src_addr_i  = SRC_BASE;
        dst_addr_i  = DST_BASE;
        mat_width_i = 6'(w);
        start_i     = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        assert (done_o == 1'b0) else begin
            $display("CHECK FAILED done_o after start with width %0d: got %h, expected %h",
                     w, done_o, 1'b0);
            errors++;
        end
        cycles = 0;
        while (done_o !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done_o !== 1'b1) begin
            $display("Timeout: width %0d job did not finish in %0d cycles", w, DONE_TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end else begin
            missing = 0;
            for (i = 0; i < (w + 2) * (w + 2); i++)
                if (hits[i] == 0)
                    missing++;
            assert (missing == 0) else begin
                $display("%0d padded positions were never written", missing);
                errors++;
            end
        end
        jobs++;
        print_job_result(w, errs_before);
    endtask

    // An invalid width must leave the engine idle
    task automatic run_rejected_start(input int w);
        int errs_before;
        int cycles;
        bit stayed_idle;
        errs_before = errors;
        stayed_idle = 1'b1;
        @(posedge clk);
        #1;
        mat_width_i = 6'(w);
        start_i     = 1'b1;
        for (cycles = 0; cycles < IDLE_WINDOW; cycles++) begin
            @(negedge clk);
            if (done_o !== 1'b1 || arvalid_o !== 1'b0)
                stayed_idle = 1'b0;
        end
        @(posedge clk);
        #1;
        start_i = 1'b0;
        assert (stayed_idle) else begin
            $display("Start with invalid width %0d was not ignored", w);
            errors++;
        end
        jobs++;
        print_job_result(w, errs_before);
    endtask

    initial begin
        rst_n       = 1'b0;
        start_i     = 1'b0;
        src_addr_i  = '0;
        dst_addr_i  = '0;
        mat_width_i = '0;
        arready_i   = 1'b0;
        rdata_i     = '0;
        rlast_i     = 1'b0;
        rvalid_i    = 1'b0;
        awready_i   = 1'b0;
        wready_i    = 1'b0;
        bvalid_i    = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_job(8);
        if (!timed_out)
            run_job(12);
        if (!timed_out)
            run_rejected_start(10);
        errors = errors + int'(i_dut.i_sva.fail_count);
        $display("Jobs run: %0d, failed checks: %0d", jobs, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: list.f
verilog/pad_geom_pkg.sv
verilog/mem_bus_pkg.sv
verilog/lane_fill_if.sv
verilog/block_sequencer.sv
verilog/block_reader.sv
verilog/pad_row_lane.sv
verilog/block_writer.sv
verilog/pad_dma_top.sv
dv/pad_dma_sva.sv
dv/tb_pad_dma.sv

// File: run.sh
#!/bin/sh
# Builds the padding DMA testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_pad_dma -Mdir "$BUILD_DIR" -o tb_pad_dma
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_pad_dma" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi
exit 0
